//--- bench/playfield_model.svh
// playfield reference model, expected color index for one raster position
`ifndef PLAYFIELD_MODEL_SVH
`define PLAYFIELD_MODEL_SVH

// included inside playfield_tb, reads its vram array and cfg_ setup variables

// display words that one group of eight pixels occupies
function automatic int group_words(input bpp_e bpp);
    case (bpp)
        BPP_1_ATTR: return 1;               // one bit per pixel in the low byte
        BPP_4:      return 2;               // four pixels per word
        default:    return 4;               // two pixels per word
    endcase
endfunction

// color index of pixel p (0 is leftmost) of the group whose first word is at base
function automatic color_t group_pixel(input bpp_e bpp, input addr_t base, input int p);
    word_t w;
    case (bpp)
        BPP_1_ATTR: begin
            w = vram[base];
            if (w[4'(7 - p)]) begin         // set bit takes the foreground
                return {4'h0, w[ATTR_FORE_LSB +: 4]};
            end
            return {4'h0, w[ATTR_BACK_LSB +: 4]};
        end
        BPP_4: begin
            w = vram[base + 16'(p / 4)];
            return {4'h0, w[4'((3 - p % 4) * 4) +: 4]};    // high nibble first
        end
        default: begin
            w = vram[base + 16'(p / 2)];
            return (p % 2 == 0) ? w[15:8] : w[7:0];
        end
    endcase
endfunction

// expected output for raster position h, v under the current setup
function automatic color_t expected_color(input int h, input int v);
    int    x;
    addr_t base;
    if (cfg_blank || v >= V_VISIBLE || h < H_TOTAL - H_VISIBLE) begin
        return cfg_border;                  // border area or blanked playfield
    end
    x    = h - (H_TOTAL - H_VISIBLE);
    base = cfg_start + 16'(v) * cfg_len + 16'((x / GROUP_PIXELS) * group_words(cfg_bpp));
    return group_pixel(cfg_bpp, base, x % GROUP_PIXELS) ^ cfg_colorbase;
endfunction

`endif

//--- bench/playfield_tb.sv
// playfield testbench, runs six display setups and checks every output pixel against a model
`default_nettype none
`timescale 1ns/1ps

module playfield_tb
    import playfield_pkg::*;
();

    localparam int H_TOTAL      = 96;       // dut defaults
    localparam int H_VISIBLE    = 64;
    localparam int V_TOTAL      = 8;
    localparam int V_VISIBLE    = 6;
    localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
    localparam int NUM_TESTS    = 6;
    localparam int CYCLE_LIMIT  = NUM_TESTS * 3 * FRAME_CYCLES * 2;    // 3 frames per test
    localparam int RESET_CYCLES = 16;
    localparam logic [31:0] SEED = 32'h9942_7d69;
    localparam int IMG_NONE     = 0;        // frame image handling
    localparam int IMG_RECORD   = 1;
    localparam int IMG_COMPARE  = 2;

    logic   clk;
    logic   reset_i;
    logic   stall_i;
    logic   blank_i;
    bpp_e   bpp_i;
    addr_t  start_addr_i;
    word_t  line_len_i;
    color_t border_color_i;
    color_t colorbase_i;
    word_t  vram_data_i;
    logic   vram_sel_o;
    addr_t  vram_addr_o;
    color_t color_o;
    hpos_t  h_pos_o;
    vpos_t  v_pos_o;

    bpp_e   cfg_bpp;                        // setup seen by the model
    addr_t  cfg_start;
    word_t  cfg_len;
    color_t cfg_border;
    color_t cfg_colorbase;
    logic   cfg_blank;

    word_t  vram [0:65535];                 // video ram contents
    color_t first_image [0:FRAME_CYCLES-1]; // frame of the first test
    addr_t  rd_addr;
    logic   rd_en;
    logic   stall_en = 1'b0;
    int     since_stall = 3;                // clocks since last stall
    int     cycle_cnt = 0;
    int     errors = 0;
    int     tests_run = 0;
    int     tests_failed = 0;

    `include "playfield_model.svh"

    playfield_top i_playfield_top (
        .clk(clk), .reset_i(reset_i), .stall_i(stall_i), .blank_i(blank_i), .bpp_i(bpp_i),
        .start_addr_i(start_addr_i), .line_len_i(line_len_i),
        .border_color_i(border_color_i), .colorbase_i(colorbase_i),
        .vram_data_i(vram_data_i), .vram_sel_o(vram_sel_o), .vram_addr_o(vram_addr_o),
        .color_o(color_o), .h_pos_o(h_pos_o), .v_pos_o(v_pos_o)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;                   // 8 ns period

    // video ram samples the request at an edge and shows the word just after it
    always @(posedge clk) begin
        rd_en   = vram_sel_o;
        rd_addr = vram_addr_o;
        #1;
        if (rd_en) begin
            vram_data_i = vram[rd_addr];
        end
    end

    // bus stall, at most one high clock in any four
    always @(posedge clk) begin
        #1;
        if (stall_en && since_stall >= 3 && ($urandom & 32'h3) == 32'h0) begin
            stall_i     = 1'b1;
            since_stall = 0;
        end else begin
            stall_i = 1'b0;
            if (since_stall < 3) begin
                since_stall++;
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("timeout, run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("TESTS FAILED");
            $finish;
        end
    end

    // returns just after the edge that shows raster position 0, 0
    task automatic wait_frame_start();
        do begin
            @(posedge clk);
            #1;
        end while (!(h_pos_o == '0 && v_pos_o == '0));
    endtask

    task automatic run_test(
        input string  name,
        input bpp_e   bpp,
        input addr_t  start,
        input word_t  len,
        input color_t border,
        input color_t cbase,
        input logic   blank,
        input logic   stall,
        input int     img_mode
    );
        int     n;
        int     h;
        int     v;
        int     test_errs;
        color_t exp_color;

        wait_frame_start();
        blank_i        = 1'b1;              // setup changes inside a blanked frame
        stall_en       = 1'b0;
        cfg_bpp        = bpp;
        cfg_start      = start;
        cfg_len        = len;
        cfg_border     = border;
        cfg_colorbase  = cbase;
        bpp_i          = bpp;
        start_addr_i   = start;
        line_len_i     = len;
        border_color_i = border;
        colorbase_i    = cbase;
        wait_frame_start();
        cfg_blank = blank;
        blank_i   = blank;
        stall_en  = stall;
        test_errs = 0;
        for (n = 0; n < FRAME_CYCLES; n++) begin
            if (n > 0) begin
                @(posedge clk);
                #1;
            end
            h = n % H_TOTAL;                // raster position from the frame count
            v = n / H_TOTAL;
            exp_color = expected_color(h, v);
            assert (int'(h_pos_o) == h && int'(v_pos_o) == v) else begin
                $display("mismatch %s raster position: expected %0d,%0d actual %0d,%0d",
                         name, v, h, v_pos_o, h_pos_o);
                test_errs++;
            end
            assert (color_o === exp_color) else begin
                $display("mismatch %s line %0d pixel %0d: expected %02h actual %02h",
                         name, v, h, exp_color, color_o);
                test_errs++;
            end
            if (img_mode == IMG_RECORD) begin
                first_image[10'(n)] = color_o;
            end
            if (img_mode == IMG_COMPARE) begin
                assert (color_o === first_image[10'(n)]) else begin
                    $display("mismatch %s image line %0d pixel %0d: expected %02h actual %02h",
                             name, v, h, first_image[10'(n)], color_o);
                    test_errs++;
                end
            end
            if (blank) begin
                assert (vram_sel_o !== 1'b1) else begin
                    $display("%s: video ram read issued at line %0d pixel %0d while blanked",
                             name, v, h);
                    test_errs++;
                end
            end
        end
        stall_en = 1'b0;
        tests_run++;
        errors += test_errs;
        if (test_errs == 0) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, test_errs);
        end
    endtask

    initial begin
        void'($urandom(SEED));
        for (int a = 0; a < 65536; a++) begin
            vram[16'(a)] = word_t'($urandom);
        end
        reset_i        = 1'b1;
        stall_i        = 1'b0;
        blank_i        = 1'b1;
        bpp_i          = BPP_8;
        start_addr_i   = '0;
        line_len_i     = '0;
        border_color_i = '0;
        colorbase_i    = '0;
        vram_data_i    = '0;
        cfg_blank      = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset_i = 1'b0;

        run_test("bpp8_base", BPP_8, 16'h0000, 16'd32, 8'h11, 8'h00, 1'b0, 1'b0, IMG_RECORD);
        run_test("bpp4_offset", BPP_4, 16'h3a50, 16'd16, 8'h22, 8'h00, 1'b0, 1'b0, IMG_NONE);
        run_test("bpp1_attr", BPP_1_ATTR, 16'hfff4, 16'd8, 8'h33, 8'h5a, 1'b0, 1'b0, IMG_NONE);
        run_test("overlap", BPP_8, 16'h1200, 16'd12, 8'h44, 8'h81, 1'b0, 1'b0, IMG_NONE);
        run_test("stall", BPP_8, 16'h0000, 16'd32, 8'h11, 8'h00, 1'b0, 1'b1, IMG_COMPARE);
        run_test("blank", BPP_8, 16'h0000, 16'd32, 8'hc6, 8'h00, 1'b1, 1'b0, IMG_NONE);

        $display("summary: %0d tests run, %0d failing, %0d errors",
                 tests_run, tests_failed, errors);
        if (tests_failed == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- hw/line_fetch.sv
// line fetch, tracks line addresses and reads display words from video ram in bursts
`default_nettype none
`timescale 1ns/1ps

module line_fetch
    import playfield_pkg::*;
(
    input  wire logic   clk,
    input  wire logic   reset_i,
    input  wire logic   stall_i,            // shared bus busy
    input  wire logic   fetch_window_i,
    input  wire logic   line_end_i,
    input  wire logic   frame_end_i,
    input  wire logic   blank_i,
    input  wire bpp_e   bpp_i,
    input  wire addr_t  start_addr_i,       // first word of the frame
    input  wire word_t  line_len_i,         // words between line starts
    input  wire word_t  vram_data_i,
    input  wire logic   words_ready_i,
    output logic        vram_sel_o,
    output addr_t       vram_addr_o,
    output logic        words_valid_o,
    output word_t       w0_o,
    output word_t       w1_o,
    output word_t       w2_o,
    output word_t       w3_o
);

    // longest stretch a burst may run past the window, reads of a 4 word group plus latency
    localparam logic [3:0] BURST_SPAN = 4'(MEM_LATENCY + 4);

    fetch_state_e   state;
    addr_t          line_start;             // start of the current line
    addr_t          cur_addr;               // next word to read
    logic [2:0]     n_words;                // words per group for this depth
    logic           issue;                  // start a read this clock
    logic           handed;                 // group has left, or leaves now
    logic [3:0]     closed_cnt;             // clocks since the window closed

    assign n_words = words_per_group(bpp_i);
    assign handed  = !words_valid_o || words_ready_i;

    always_comb begin
        case (state)
            ADDR:    issue = fetch_window_i && !blank_i && !stall_i && handed;
            WAIT:    issue = (n_words != 3'd1);     // second word for 4 and 8 bpp
            READ_0:  issue = (n_words == 3'd4);     // third word, 8 bpp only
            READ_1:  issue = (n_words == 3'd4);     // fourth word
            default: issue = 1'b0;
        endcase
        if (line_end_i) begin
            issue = 1'b0;                   // line flush drops the burst
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state         <= IDLE;
            vram_sel_o    <= 1'b0;
            words_valid_o <= 1'b0;
            line_start    <= '0;
            cur_addr      <= '0;
        end else begin
            vram_sel_o <= issue;
            if (issue) begin
                cur_addr <= cur_addr + 1'b1;
            end
            if (words_valid_o && words_ready_i) begin
                words_valid_o <= 1'b0;      // expander took the words
            end
            case (state)
                IDLE: begin
                    if (fetch_window_i && !blank_i && !stall_i) begin
                        state <= ADDR;
                    end
                end
                ADDR: begin
                    if (!fetch_window_i || blank_i) begin
                        state <= IDLE;
                    end else if (issue) begin
                        state <= WAIT;
                    end
                end
                WAIT: state <= READ_0;
                READ_0: begin
                    if (n_words == 3'd1) begin
                        words_valid_o <= 1'b1;      // 1 bpp group complete
                        state         <= ADDR;
                    end else begin
                        state <= READ_1;
                    end
                end
                READ_1: begin
                    if (n_words == 3'd2) begin
                        words_valid_o <= 1'b1;      // 4 bpp group complete
                        state         <= ADDR;
                    end else begin
                        state <= READ_2;
                    end
                end
                READ_2: state <= READ_3;
                READ_3: begin
                    words_valid_o <= 1'b1;          // 8 bpp group complete
                    state         <= ADDR;
                end
                default: state <= IDLE;
            endcase
            if (frame_end_i || blank_i) begin
                line_start <= start_addr_i;         // back to top of frame
                cur_addr   <= start_addr_i;
            end else if (line_end_i) begin
                line_start <= line_start + line_len_i;
                cur_addr   <= line_start + line_len_i;
            end
            if (line_end_i) begin
                state         <= IDLE;
                words_valid_o <= 1'b0;              // leftover group belongs to old line
            end
        end
    end

    // read address and collected words, sampled MEM_LATENCY edges after each request
    always_ff @(posedge clk) begin
        if (issue) begin
            vram_addr_o <= cur_addr;
        end
        if (state == READ_0) begin
            w0_o <= vram_data_i;
        end
        if (state == READ_1) begin
            w1_o <= vram_data_i;
        end
        if (state == READ_2) begin
            w2_o <= vram_data_i;
        end
        if (state == READ_3) begin
            w3_o <= vram_data_i;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i || fetch_window_i) begin
            closed_cnt <= '0;
        end else if (closed_cnt != 4'hf) begin
            closed_cnt <= closed_cnt + 1'b1;    // saturate
        end
    end

    // video ram may only be busy during the window or the tail of one burst
    assert property (@(posedge clk) disable iff (reset_i)
        vram_sel_o |-> (closed_cnt <= BURST_SPAN))
        else $error("vram read outside fetch window");

endmodule

`default_nettype wire

//--- hw/pixel_expand.sv
// pixel expander, turns fetched words into one group of eight 8-bit color indices
`default_nettype none
`timescale 1ns/1ps

module pixel_expand
    import playfield_pkg::*;
(
    input  wire logic   clk,
    input  wire logic   reset_i,
    input  wire bpp_e   bpp_i,
    input  wire logic   words_valid_i,
    input  wire word_t  w0_i,
    input  wire word_t  w1_i,
    input  wire word_t  w2_i,
    input  wire word_t  w3_i,
    input  wire logic   grp_ready_i,        // shifter loaded the group
    input  wire logic   line_end_i,
    output logic        words_ready_o,
    output logic        grp_valid_o,
    output logic [63:0] grp_pixels_o        // first pixel in the top byte
);

    logic [63:0] expanded;                  // decoded group from the current words
    logic [31:0] nibs;                      // 4 bpp source, w0 then w1
    logic        take;                      // words transfer this clock

    assign words_ready_o = !grp_valid_o;    // ready while buffer empty
    assign take          = words_valid_i && words_ready_o;
    assign nibs          = {w0_i, w1_i};

    always_comb begin
        case (bpp_i)
            BPP_1_ATTR: begin
                for (int i = 0; i < GROUP_PIXELS; i++) begin
                    // bit 7 is the leftmost pixel
                    expanded[i*8 +: 8] = {4'h0, w0_i[i] ? w0_i[ATTR_FORE_LSB +: 4]
                                                        : w0_i[ATTR_BACK_LSB +: 4]};
                end
            end
            BPP_4: begin
                for (int i = 0; i < GROUP_PIXELS; i++) begin
                    expanded[i*8 +: 8] = {4'h0, nibs[i*4 +: 4]};    // msb nibble first
                end
            end
            default: expanded = {w0_i, w1_i, w2_i, w3_i};           // 8 bpp and code 3
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            grp_valid_o <= 1'b0;
        end else if (line_end_i) begin
            grp_valid_o <= 1'b0;            // drop leftover group at end of line
        end else if (take) begin
            grp_valid_o <= 1'b1;
        end else if (grp_ready_i) begin
            grp_valid_o <= 1'b0;            // buffer emptied by shifter load
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            grp_pixels_o <= expanded;
        end
    end

endmodule

`default_nettype wire

//--- hw/pixel_shifter.sv
// pixel shifter, scans each group out one pixel per clock with border and color base
`default_nettype none
`timescale 1ns/1ps

module pixel_shifter
    import playfield_pkg::*;
(
    input  wire logic   clk,
    input  wire logic   reset_i,
    input  wire logic   scan_start_i,       // first group of the line
    input  wire logic   line_end_i,
    input  wire logic   visible_i,
    input  wire logic   blank_i,
    input  wire logic   grp_valid_i,
    input  wire logic [63:0] grp_pixels_i,
    input  wire color_t border_color_i,
    input  wire color_t colorbase_i,        // xor'd into every pixel
    output logic        grp_ready_o,        // one clock pulse per load
    output color_t      color_o
);

    logic [63:0] shreg;                     // pixels in flight, current in top byte
    logic [2:0]  pix_cnt;                   // pixel within the group
    logic        load;

    // no refill on the last pixel of the line, the next line starts at scan_start
    assign load = !blank_i && (scan_start_i ||
                  (visible_i && pix_cnt == 3'(GROUP_PIXELS - 1) && !line_end_i));
    assign grp_ready_o = load;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            pix_cnt <= '0;
            color_o <= border_color_i;
        end else begin
            if (scan_start_i) begin
                pix_cnt <= '0;
            end else if (visible_i) begin
                pix_cnt <= pix_cnt + 1'b1;  // wraps every group
            end
            if (visible_i && !blank_i) begin
                color_o <= shreg[63:56] ^ colorbase_i;
            end else begin
                color_o <= border_color_i;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            shreg <= grp_pixels_i;
        end else if (visible_i) begin
            shreg <= {shreg[55:0], 8'h00};  // next pixel to top
        end
    end

    // fetch and expander must keep ahead of scanout
    assert property (@(posedge clk) disable iff (reset_i) load |-> grp_valid_i)
        else $error("pixel group underrun");

endmodule

`default_nettype wire

//--- hw/playfield_pkg.sv
// playfield package with the shared word, address and color types and the depth encodings
`default_nettype none

package playfield_pkg;

    typedef logic [15:0] word_t;            // one video ram data word
    typedef logic [15:0] addr_t;            // video ram word address (64K words)
    typedef logic [7:0]  color_t;           // 8-bit color index
    typedef logic [7:0]  hpos_t;            // horizontal pixel count
    typedef logic [5:0]  vpos_t;            // line count

    // display depth, code 3 decodes like BPP_8
    typedef enum logic [1:0] {
        BPP_1_ATTR = 2'd0,                  // 1 bpp with fore/back attribute nibbles
        BPP_4      = 2'd1,                  // 4 bpp, two words per group
        BPP_8      = 2'd2                   // 8 bpp, four words per group
    } bpp_e;

    // display word fetch states
    typedef enum logic [2:0] {
        IDLE,                               // waiting for the fetch window
        ADDR,                               // issue first read of a group
        WAIT,                               // first read in flight
        READ_0,                             // capture word 0
        READ_1,                             // capture word 1
        READ_2,                             // capture word 2
        READ_3                              // capture word 3
    } fetch_state_e;

    localparam int ATTR_FORE_LSB = 12;      // foreground nibble of a 1 bpp word
    localparam int ATTR_BACK_LSB = 8;       // background nibble of a 1 bpp word
    localparam int GROUP_PIXELS  = 8;       // pixels per expanded group
    localparam int MEM_LATENCY   = 2;       // clocks from read request to data

    // video ram words needed for one group of eight pixels
    function automatic logic [2:0] words_per_group(input bpp_e bpp);
        case (bpp)
            BPP_1_ATTR: return 3'd1;        // 8 pixels in the low byte
            BPP_4:      return 3'd2;        // 4 pixels per word
            default:    return 3'd4;        // 2 pixels per word
        endcase
    endfunction

endpackage

`default_nettype wire

//--- hw/playfield_top.sv
// playfield top, connects raster timing, line fetch, expander and shifter
`default_nettype none
`timescale 1ns/1ps

module playfield_top
    import playfield_pkg::*;
#(
    parameter int H_TOTAL    = 96,
    parameter int H_VISIBLE  = 64,
    parameter int V_TOTAL    = 8,
    parameter int V_VISIBLE  = 6,
    parameter int FETCH_LEAD = 24
) (
    input  wire logic   clk,
    input  wire logic   reset_i,
    input  wire logic   stall_i,
    input  wire logic   blank_i,
    input  wire bpp_e   bpp_i,
    input  wire addr_t  start_addr_i,
    input  wire word_t  line_len_i,
    input  wire color_t border_color_i,
    input  wire color_t colorbase_i,
    input  wire word_t  vram_data_i,
    output logic        vram_sel_o,
    output addr_t       vram_addr_o,
    output color_t      color_o,
    output hpos_t       h_pos_o,
    output vpos_t       v_pos_o
);

    logic        fetch_window;              // timing strobes
    logic        line_end;
    logic        frame_end;
    logic        scan_start;
    logic        visible;
    logic        words_valid;               // fetch to expander
    logic        words_ready;
    word_t       w0;
    word_t       w1;
    word_t       w2;
    word_t       w3;
    logic        grp_valid;                 // expander to shifter
    logic        grp_ready;
    logic [63:0] grp_pixels;

    raster_timing #(
        .H_TOTAL(H_TOTAL), .H_VISIBLE(H_VISIBLE), .V_TOTAL(V_TOTAL),
        .V_VISIBLE(V_VISIBLE), .FETCH_LEAD(FETCH_LEAD)
    ) i_raster_timing (
        .clk(clk), .reset_i(reset_i), .h_pos_o(h_pos_o), .v_pos_o(v_pos_o),
        .fetch_window_o(fetch_window), .line_end_o(line_end), .frame_end_o(frame_end),
        .scan_start_o(scan_start), .visible_o(visible)
    );

    line_fetch i_line_fetch (
        .clk(clk), .reset_i(reset_i), .stall_i(stall_i), .fetch_window_i(fetch_window),
        .line_end_i(line_end), .frame_end_i(frame_end), .blank_i(blank_i), .bpp_i(bpp_i),
        .start_addr_i(start_addr_i), .line_len_i(line_len_i), .vram_data_i(vram_data_i),
        .words_ready_i(words_ready), .vram_sel_o(vram_sel_o), .vram_addr_o(vram_addr_o),
        .words_valid_o(words_valid), .w0_o(w0), .w1_o(w1), .w2_o(w2), .w3_o(w3)
    );

    pixel_expand i_pixel_expand (
        .clk(clk), .reset_i(reset_i), .bpp_i(bpp_i), .words_valid_i(words_valid),
        .w0_i(w0), .w1_i(w1), .w2_i(w2), .w3_i(w3), .grp_ready_i(grp_ready),
        .line_end_i(line_end), .words_ready_o(words_ready), .grp_valid_o(grp_valid),
        .grp_pixels_o(grp_pixels)
    );

    pixel_shifter i_pixel_shifter (
        .clk(clk), .reset_i(reset_i), .scan_start_i(scan_start), .line_end_i(line_end),
        .visible_i(visible), .blank_i(blank_i), .grp_valid_i(grp_valid),
        .grp_pixels_i(grp_pixels), .border_color_i(border_color_i),
        .colorbase_i(colorbase_i), .grp_ready_o(grp_ready), .color_o(color_o)
    );

endmodule

`default_nettype wire

//--- hw/raster_timing.sv
// raster timing, pixel and line counters with the fetch window and scanout strobes
`default_nettype none
`timescale 1ns/1ps

module raster_timing
    import playfield_pkg::*;
#(
    parameter int H_TOTAL    = 96,          // clocks per line
    parameter int H_VISIBLE  = 64,          // visible pixels at the end of a line
    parameter int V_TOTAL    = 8,           // lines per frame
    parameter int V_VISIBLE  = 6,           // visible lines at the start of a frame
    parameter int FETCH_LEAD = 24           // fetch opens this early before scanout
) (
    input  wire logic   clk,
    input  wire logic   reset_i,
    output hpos_t       h_pos_o,            // counter copy, one clock behind
    output vpos_t       v_pos_o,
    output logic        fetch_window_o,     // memory fetch allowed
    output logic        line_end_o,         // last count of a line
    output logic        frame_end_o,        // last count of a frame
    output logic        scan_start_o,       // load first group for the line
    output logic        visible_o           // inside the visible window
);

    localparam hpos_t H_LAST      = hpos_t'(H_TOTAL - 1);
    localparam hpos_t H_VIS_START = hpos_t'(H_TOTAL - H_VISIBLE);
    localparam hpos_t H_FETCH     = hpos_t'(H_TOTAL - H_VISIBLE - FETCH_LEAD);
    localparam vpos_t V_LAST      = vpos_t'(V_TOTAL - 1);
    localparam vpos_t V_VIS_END   = vpos_t'(V_VISIBLE);

    hpos_t  h_cnt;                          // current pixel count
    vpos_t  v_cnt;                          // current line count
    logic   line_vis;                       // current line carries pixels

    assign line_vis       = (v_cnt < V_VIS_END);
    assign line_end_o     = (h_cnt == H_LAST);
    assign frame_end_o    = line_end_o && (v_cnt == V_LAST);
    assign visible_o      = line_vis && (h_cnt >= H_VIS_START);
    assign fetch_window_o = line_vis && (h_cnt >= H_FETCH);     // open to end of line
    assign scan_start_o   = line_vis && (h_cnt == H_VIS_START - 1'b1);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            h_cnt   <= '0;
            v_cnt   <= '0;
            h_pos_o <= '0;
            v_pos_o <= '0;
        end else begin
            h_pos_o <= h_cnt;               // align with the registered color
            v_pos_o <= v_cnt;
            if (line_end_o) begin
                h_cnt <= '0;
                v_cnt <= frame_end_o ? '0 : v_cnt + 1'b1;
            end else begin
                h_cnt <= h_cnt + 1'b1;
            end
        end
    end

    // line and frame strobes drive the address bookkeeping, so each must be single clock
    assert property (@(posedge clk) disable iff (reset_i) line_end_o |=> !line_end_o)
        else $error("line_end held longer than one clock");
    assert property (@(posedge clk) disable iff (reset_i) frame_end_o |=> !frame_end_o)
        else $error("frame_end held longer than one clock");

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# compile and run the playfield simulation with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/1ps --top-module playfield_tb -f sim.f
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/Vplayfield_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "^TESTS PASSED$"; then
    exit 0
fi
exit 1

//--- sim.f
+incdir+bench
hw/playfield_pkg.sv
hw/raster_timing.sv
hw/line_fetch.sv
hw/pixel_expand.sv
hw/pixel_shifter.sv
hw/playfield_top.sv
bench/playfield_tb.sv
